//--- common/soc_pkg.sv
package soc_pkg;

   // Bus widths
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 32;
   localparam int N_SLAVES = 4;

   // Region field sits in the top address bits
   localparam int REGION_W = 3;
   localparam int OFFSET_W = ADDR_W - REGION_W;

   // Region numbers, also the slave port indices
   localparam int BOOT_BASE       = 0;
   localparam int RAM_BASE        = 1;
   localparam int UART_BASE       = 2;
   localparam int SOFT_RESET_BASE = 3;

   // Byte address widths of the two RAMs
   localparam int BOOT_ADDR_W = 10;
   localparam int RAM_ADDR_W  = 12;

   // UART register map, word index from address bits 4:2
   localparam logic [2:0] UART_TXDATA = 3'd0;
   localparam logic [2:0] UART_STATUS = 3'd1;
   localparam logic [2:0] UART_RXDATA = 3'd2;
   localparam logic [2:0] UART_DIV    = 3'd3;

   localparam int                    UART_DIV_W     = 16;
   localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd16;

   // Region and offset view of a bus address
   typedef struct packed {
      logic [REGION_W-1:0] region;
      logic [OFFSET_W-1:0] offset;
   } soc_addr_s;

   typedef union packed {
      logic [ADDR_W-1:0] raw;
      soc_addr_s         f;
   } soc_addr_u;

endpackage

//--- rtl/bus_interconnect.sv
`timescale 1ns/1ps

module bus_interconnect (
   input  logic                                      boot,
   input  soc_pkg::soc_addr_u                        m_addr,
   input  logic                                      m_valid,
   output logic                                      m_ready,
   output logic [soc_pkg::DATA_W-1:0]                m_rdata,
   output logic [soc_pkg::N_SLAVES-1:0]              s_valid,
   input  logic [soc_pkg::N_SLAVES-1:0]              s_ready,
   input  logic [soc_pkg::N_SLAVES*soc_pkg::DATA_W-1:0] s_rdata
);

   import soc_pkg::*;

   logic [REGION_W-1:0] region;

   // Region 0 maps to boot RAM only while booting
   always_comb begin
      region = m_addr.f.region;
      if (!boot && region == REGION_W'(BOOT_BASE)) begin
         region = REGION_W'(RAM_BASE);
      end
   end

   // Valid fan-out and return path
   // Unmapped regions select nothing, so ready stays low there
   always_comb begin
      s_valid = '0;
      m_ready = 1'b0;
      m_rdata = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (region == REGION_W'(i)) begin
            s_valid[i] = m_valid;
            m_ready    = s_ready[i];
            m_rdata    = s_rdata[i*DATA_W +: DATA_W];
         end
      end
   end

   // At most one slave answers at a time
   always_comb begin
      assert final ($onehot0(s_ready))
         else $error("bus_interconnect: s_ready multi-hot %b", s_ready);
   end

endmodule

//--- rtl/soc_ram.sv
`timescale 1ns/1ps

module soc_ram #(
   parameter int ADDR_W = 8
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         valid,
   input  logic [ADDR_W-1:0]            addr,
   input  logic [soc_pkg::DATA_W-1:0]   wdata,
   input  logic [soc_pkg::DATA_W/8-1:0] wstrb,
   output logic [soc_pkg::DATA_W-1:0]   rdata,
   output logic                         ready
);

   import soc_pkg::*;

   localparam int N_LANES = DATA_W / 8;

   logic [DATA_W-1:0] mem [0:2**ADDR_W-1];

   // Byte lane writes, registered read
   always_ff @(posedge clk) begin
      if (valid) begin
         for (int i = 0; i < N_LANES; i++) begin
            if (wstrb[i]) begin
               mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
         end
         rdata <= mem[addr];
      end
   end

   // One-cycle acknowledge, dropped again after a single cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= valid && !ready;
      end
   end

   // Master must hold valid through the ready cycle
   assert property (@(posedge clk) disable iff (reset) ready |-> valid)
      else $error("soc_ram: ready without valid");

endmodule

//--- rtl/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       valid,
   input  logic                       write,
   output logic                       ready,
   output logic [soc_pkg::DATA_W-1:0] rdata,
   output logic                       boot,
   output logic                       soft_reset
);

   import soc_pkg::*;

   logic access;

   // First cycle of a request
   assign access = valid && !ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready      <= 1'b0;
         soft_reset <= 1'b0;
         boot       <= 1'b1;
      end else begin
         ready      <= access;
         soft_reset <= access && write;
         // Boot stays cleared until the next hard reset
         if (access && write) begin
            boot <= 1'b0;
         end
      end
   end

   assign rdata = {{(DATA_W-1){1'b0}}, boot};

   // The write that caused the pulse is still held by the master
   assert property (@(posedge clk) disable iff (reset) soft_reset |-> valid && write)
      else $error("reset_ctrl: write request dropped during soft_reset");

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           start,
   input  logic [7:0]                     data,
   input  logic [soc_pkg::UART_DIV_W-1:0] div,
   output logic                           busy,
   output logic                           txd
);

   import soc_pkg::*;

   // Stop, data LSB first, start; bit 0 drives the line
   logic [9:0]            shreg;
   logic [3:0]            bit_cnt;
   logic [UART_DIV_W-1:0] div_cnt;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         shreg   <= '1;
         bit_cnt <= '0;
         div_cnt <= '0;
         busy    <= 1'b0;
      end else if (!busy) begin
         if (start) begin
            shreg   <= {1'b1, data, 1'b0};
            bit_cnt <= '0;
            div_cnt <= '0;
            busy    <= 1'b1;
         end
      end else if (div_cnt == div - 1'b1) begin
         // End of one bit period
         div_cnt <= '0;
         shreg   <= {1'b1, shreg[9:1]};
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Ones shift in behind the stop bit, so the line idles high
   assign txd = shreg[0];

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           rxd,
   input  logic [soc_pkg::UART_DIV_W-1:0] div,
   output logic [7:0]                     data,
   output logic                           strobe
);

   import soc_pkg::*;

   logic [1:0]            rxd_sync;
   logic                  rxd_s;
   logic                  active;
   logic [3:0]            bit_idx;
   logic [UART_DIV_W-1:0] cnt;
   logic [7:0]            shreg;
   logic                  sample;

   // Two-flop synchronizer, idles high like the line
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rxd_sync <= 2'b11;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
      end
   end

   assign rxd_s  = rxd_sync[1];
   assign sample = active && cnt == '0;

   // bit_idx 0 is the start bit, 1 to 8 data, 9 stop
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         active  <= 1'b0;
         bit_idx <= '0;
         cnt     <= '0;
         strobe  <= 1'b0;
      end else begin
         strobe <= 1'b0;
         if (!active) begin
            if (!rxd_s) begin
               // Half a period to land in the middle of the start bit
               active  <= 1'b1;
               bit_idx <= '0;
               cnt     <= div >> 1;
            end
         end else if (!sample) begin
            cnt <= cnt - 1'b1;
         end else begin
            cnt     <= div - 1'b1;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd0) begin
               // Glitch, not a real start bit
               if (rxd_s) begin
                  active <= 1'b0;
               end
            end else if (bit_idx == 4'd9) begin
               active <= 1'b0;
               // Framing error drops the byte
               strobe <= rxd_s;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sample && bit_idx inside {[4'd1:4'd8]}) begin
         shreg <= {rxd_s, shreg[7:1]};
      end
   end

   assign data = shreg;

endmodule

//--- uart/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         valid,
   input  logic [2:0]                   addr,
   input  logic [soc_pkg::DATA_W-1:0]   wdata,
   input  logic [soc_pkg::DATA_W/8-1:0] wstrb,
   output logic [soc_pkg::DATA_W-1:0]   rdata,
   output logic                         ready,
   output logic                         txd,
   input  logic                         rxd,
   output logic                         rts,
   input  logic                         cts
);

   import soc_pkg::*;

   logic                  access;
   logic                  write;
   logic                  tx_load;
   logic                  tx_start;
   logic                  tx_busy;
   logic                  tx_pend;
   logic [7:0]            tx_byte;
   logic                  rx_read;
   logic                  rx_strobe;
   logic [7:0]            rx_data;
   logic [7:0]            rx_byte;
   logic                  rx_valid;
   logic                  overrun;
   logic [UART_DIV_W-1:0] div;

   assign access  = valid && !ready;
   assign write   = |wstrb;
   // Bytes written while busy or holding are lost
   assign tx_load = access && write && addr == UART_TXDATA && !tx_busy && !tx_pend;
   assign rx_read = access && !write && addr == UART_RXDATA;
   // Held byte waits here for cts
   assign tx_start = tx_pend && cts && !tx_busy;
   assign rts      = !rx_valid;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready    <= 1'b0;
         tx_pend  <= 1'b0;
         rx_valid <= 1'b0;
         overrun  <= 1'b0;
         div      <= UART_DIV_RESET;
      end else begin
         ready <= access;
         if (tx_load) begin
            tx_pend <= 1'b1;
         end else if (tx_start) begin
            tx_pend <= 1'b0;
         end
         if (access && write && addr == UART_DIV) begin
            div <= wdata[UART_DIV_W-1:0];
         end
         if (rx_read) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
         end
         // New byte wins over a read in the same cycle
         if (rx_strobe) begin
            rx_valid <= 1'b1;
            if (rx_valid && !rx_read) begin
               overrun <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_load) begin
         tx_byte <= wdata[7:0];
      end
      if (rx_strobe) begin
         rx_byte <= rx_data;
      end
      if (access) begin
         case (addr)
            UART_STATUS: rdata <= {{(DATA_W-3){1'b0}}, overrun, rx_valid, tx_busy};
            UART_RXDATA: rdata <= {{(DATA_W-8){1'b0}}, rx_byte};
            UART_DIV:    rdata <= {{(DATA_W-UART_DIV_W){1'b0}}, div};
            default:     rdata <= '0;
         endcase
      end
   end

   uart_tx tx (
      .clk   (clk),
      .reset (reset),
      .start (tx_start),
      .data  (tx_byte),
      .div   (div),
      .busy  (tx_busy),
      .txd   (txd)
   );

   uart_rx rx (
      .clk    (clk),
      .reset  (reset),
      .rxd    (rxd),
      .div    (div),
      .data   (rx_data),
      .strobe (rx_strobe)
   );

   // A frame only begins after a cycle with cts high
   assert property (@(posedge clk) disable iff (reset) $rose(tx_busy) |-> $past(cts))
      else $error("uart_regs: transmit started with cts low");

endmodule

//--- rtl/soc_system.sv
`timescale 1ns/1ps

module soc_system (
   input  logic                         clk,
   input  logic                         reset,
   // Master port
   input  logic                         m_valid,
   input  soc_pkg::soc_addr_u           m_addr,
   input  logic [soc_pkg::DATA_W-1:0]   m_wdata,
   input  logic [soc_pkg::DATA_W/8-1:0] m_wstrb,
   output logic [soc_pkg::DATA_W-1:0]   m_rdata,
   output logic                         m_ready,
   // UART pins
   output logic                         txd,
   input  logic                         rxd,
   output logic                         rts,
   input  logic                         cts,
   output logic                         core_reset,
   output logic                         boot_mode
);

   import soc_pkg::*;

   logic                       boot;
   logic                       soft_reset;
   logic [N_SLAVES-1:0]        s_valid;
   logic [N_SLAVES-1:0]        s_ready;
   logic [N_SLAVES*DATA_W-1:0] s_rdata;

   assign core_reset = reset | soft_reset;
   assign boot_mode  = boot;

   bus_interconnect xbar (
      .boot    (boot),
      .m_addr  (m_addr),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_rdata (m_rdata),
      .s_valid (s_valid),
      .s_ready (s_ready),
      .s_rdata (s_rdata)
   );

   soc_ram #(
      .ADDR_W(BOOT_ADDR_W-2)
   ) boot_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[BOOT_BASE]),
      .addr  (m_addr.f.offset[BOOT_ADDR_W-1:2]),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .rdata (s_rdata[BOOT_BASE*DATA_W +: DATA_W]),
      .ready (s_ready[BOOT_BASE])
   );

   soc_ram #(
      .ADDR_W(RAM_ADDR_W-2)
   ) main_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[RAM_BASE]),
      .addr  (m_addr.f.offset[RAM_ADDR_W-1:2]),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .rdata (s_rdata[RAM_BASE*DATA_W +: DATA_W]),
      .ready (s_ready[RAM_BASE])
   );

   uart_regs uart (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[UART_BASE]),
      .addr  (m_addr.f.offset[4:2]),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .rdata (s_rdata[UART_BASE*DATA_W +: DATA_W]),
      .ready (s_ready[UART_BASE]),
      .txd   (txd),
      .rxd   (rxd),
      .rts   (rts),
      .cts   (cts)
   );

   reset_ctrl rst_ctrl (
      .clk        (clk),
      .reset      (reset),
      .valid      (s_valid[SOFT_RESET_BASE]),
      .write      (|m_wstrb),
      .ready      (s_ready[SOFT_RESET_BASE]),
      .rdata      (s_rdata[SOFT_RESET_BASE*DATA_W +: DATA_W]),
      .boot       (boot),
      .soft_reset (soft_reset)
   );

endmodule

//--- verif/soc_system_tb.sv
`timescale 1ns/1ps

module soc_system_tb;

   import soc_pkg::*;

   localparam int OP_WRITE = 0;
   localparam int OP_READ  = 1;
   localparam int OP_WAIT  = 2;
   localparam int OP_QUIET = 3;
   localparam int PIN_NONE = 0;
   localparam int PIN_RTS  = 1;
   localparam int PIN_BOOT = 2;
   localparam int ACK_TIMEOUT = 20;
   localparam int POLL_LIMIT  = 400;
   localparam logic [15:0] LFSR_SEED = 16'd51931;

   // One table row; OP_QUIET keeps the cycle count in wdata
   typedef struct {
      int          test;
      int          op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  strb;
      logic [31:0] mask;
      logic [31:0] exp;
      logic        cts;
      int          pin;
      logic        pin_exp;
   } row_t;

   logic        clk;
   logic        reset;
   logic        m_valid;
   soc_addr_u   m_addr;
   logic [31:0] m_wdata;
   logic [3:0]  m_wstrb;
   logic [31:0] m_rdata;
   logic        m_ready;
   logic        txd;
   logic        rxd;
   logic        rts;
   logic        cts;
   logic        core_reset;
   logic        boot_mode;

   row_t        rows[$];
   string       test_name [0:6];
   int          n_pass;
   int          n_fail;
   int          test_fail;
   logic        timed_out;
   logic [15:0] lfsr;
   logic [31:0] rd_data;

   soc_system UUT (
      .clk        (clk),
      .reset      (reset),
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .m_rdata    (m_rdata),
      .m_ready    (m_ready),
      .txd        (txd),
      .rxd        (rxd),
      .rts        (rts),
      .cts        (cts),
      .core_reset (core_reset),
      .boot_mode  (boot_mode)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // UART loopback
   always @(negedge clk) rxd = txd;

   // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) s = s ^ 16'hB400;
      return s;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // Each strobe bit replaces one byte lane
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, new_w,
                                               input logic [3:0] strb);
      logic [31:0] w;
      w = old_w;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) w[i*8 +: 8] = new_w[i*8 +: 8];
      end
      return w;
   endfunction

   function automatic logic [31:0] region_addr(input int region, input logic [28:0] offset);
      soc_addr_u a;
      a.f.region = REGION_W'(region);
      a.f.offset = offset;
      return a.raw;
   endfunction

   task automatic check(input logic ok, input string msg);
      assert (ok) n_pass++;
      else begin
         n_fail++;
         test_fail++;
         $display("CHECK FAILED at %0t: %s", $time, msg);
      end
   endtask

   task automatic add_row(input int test, op, input logic [31:0] addr, wdata,
                          input logic [3:0] strb, input logic [31:0] mask, exp,
                          input logic c, input int pin, input logic pin_exp);
      row_t r;
      r = '{test, op, addr, wdata, strb, mask, exp, c, pin, pin_exp};
      rows.push_back(r);
   endtask

   // Entered on a falling edge, returns on a falling edge with valid dropped
   task automatic bus_access(input logic [31:0] addr, wdata, input logic [3:0] strb);
      int   cycles;
      logic exp_core;
      m_addr.raw = addr;
      m_wdata    = wdata;
      m_wstrb    = strb;
      m_valid    = 1'b1;
      exp_core   = (|strb) && addr[31:29] == 3'(SOFT_RESET_BASE);
      @(negedge clk);
      cycles = 1;
      while (!m_ready && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!m_ready) begin
         $display("Bus access to %h got no m_ready within %0d cycles", addr, cycles);
         n_fail++;
         test_fail++;
         timed_out = 1'b1;
         m_valid   = 1'b0;
      end else begin
         rd_data = m_rdata;
         check(cycles == 1, $sformatf("access %h: ready after %0d cycles", addr, cycles));
         check(core_reset == exp_core,
               $sformatf("access %h: core_reset %b, expected %b", addr, core_reset, exp_core));
         @(negedge clk);
         m_valid = 1'b0;
      end
   endtask

   task automatic run_row(input row_t r);
      int   polls;
      logic seen;
      logic quiet;
      cts = r.cts;
      case (r.op)
         OP_WRITE: bus_access(r.addr, r.wdata, r.strb);
         OP_READ: begin
            bus_access(r.addr, '0, '0);
            check((rd_data & r.mask) == r.exp,
                  $sformatf("read %h returned %h, expected %h", r.addr, rd_data, r.exp));
         end
         OP_WAIT: begin
            polls = 0;
            seen  = 1'b0;
            while (!seen && !timed_out && polls < POLL_LIMIT) begin
               bus_access(r.addr, '0, '0);
               seen = (rd_data & r.mask) == r.exp;
               polls++;
            end
            assert (seen) n_pass++;
            else begin
               n_fail++;
               test_fail++;
               $display("Polling %h gave up after %0d reads, flags %h never matched %h",
                        r.addr, polls, rd_data & r.mask, r.exp);
            end
         end
         default: begin
            quiet = 1'b1;
            for (int n = 0; n < r.wdata; n++) begin
               @(negedge clk);
               quiet = quiet & txd;
            end
            check(quiet, "txd left idle level while cts was low");
         end
      endcase
      if (r.pin == PIN_RTS)
         check(rts == r.pin_exp, $sformatf("rts is %b, expected %b", rts, r.pin_exp));
      if (r.pin == PIN_BOOT)
         check(boot_mode == r.pin_exp,
               $sformatf("boot_mode is %b, expected %b", boot_mode, r.pin_exp));
   endtask

   task automatic build_table();
      logic [31:0] w0, w1, w2, m1, b1;
      logic [31:0] tx_a, st_a, rx_a;
      logic [7:0]  c0, c1, c2, c3;
      tx_a = region_addr(UART_BASE, {UART_TXDATA, 2'b00});
      st_a = region_addr(UART_BASE, {UART_STATUS, 2'b00});
      rx_a = region_addr(UART_BASE, {UART_RXDATA, 2'b00});
      w0 = rand_bits(32);
      w1 = rand_bits(32);
      w2 = rand_bits(32);
      add_row(1, OP_WRITE, region_addr(0, 'h10), w0, 4'hF, '0, '0, 1, PIN_NONE, 0);
      add_row(1, OP_WRITE, region_addr(0, 'h10), w1, 4'b0010, '0, '0, 1, PIN_NONE, 0);
      add_row(1, OP_WRITE, region_addr(0, 'h10), w2, 4'b1000, '0, '0, 1, PIN_NONE, 0);
      add_row(1, OP_READ, region_addr(0, 'h10), '0, '0, '1,
              merge_bytes(merge_bytes(w0, w1, 4'b0010), w2, 4'b1000), 1, PIN_NONE, 0);
      m1 = rand_bits(32);
      b1 = rand_bits(32);
      if (b1 == m1) b1 = ~m1;
      add_row(2, OP_WRITE, region_addr(1, 'h20), m1, 4'hF, '0, '0, 1, PIN_NONE, 0);
      add_row(2, OP_WRITE, region_addr(0, 'h20), b1, 4'hF, '0, '0, 1, PIN_NONE, 0);
      add_row(2, OP_READ, region_addr(0, 'h20), '0, '0, '1, b1, 1, PIN_BOOT, 1);
      add_row(2, OP_READ, region_addr(1, 'h20), '0, '0, '1, m1, 1, PIN_NONE, 0);
      add_row(2, OP_READ, region_addr(3, 'h0), '0, '0, '1, 32'd1, 1, PIN_NONE, 0);
      // Four clocks per bit keeps frames short
      c0 = rand_bits(8);
      add_row(3, OP_WRITE, region_addr(UART_BASE, {UART_DIV, 2'b00}), 32'd4, 4'hF,
              '0, '0, 1, PIN_NONE, 0);
      add_row(3, OP_WRITE, tx_a, 32'(c0), 4'h1, '0, '0, 1, PIN_NONE, 0);
      add_row(3, OP_WAIT, st_a, '0, '0, 32'h3, 32'h2, 1, PIN_RTS, 0);
      add_row(3, OP_READ, rx_a, '0, '0, '1, 32'(c0), 1, PIN_RTS, 1);
      c1 = rand_bits(8);
      add_row(4, OP_WRITE, tx_a, 32'(c1), 4'h1, '0, '0, 0, PIN_NONE, 0);
      add_row(4, OP_READ, st_a, '0, '0, 32'h7, 32'h0, 0, PIN_NONE, 0);
      add_row(4, OP_QUIET, '0, 32'd60, '0, '0, '0, 0, PIN_NONE, 0);
      add_row(4, OP_WAIT, st_a, '0, '0, 32'h3, 32'h2, 1, PIN_NONE, 0);
      add_row(4, OP_READ, rx_a, '0, '0, '1, 32'(c1), 1, PIN_RTS, 1);
      c2 = rand_bits(8);
      c3 = rand_bits(8);
      if (c3 == c2) c3 = ~c2;
      add_row(5, OP_WRITE, tx_a, 32'(c2), 4'h1, '0, '0, 1, PIN_NONE, 0);
      add_row(5, OP_WAIT, st_a, '0, '0, 32'h3, 32'h2, 1, PIN_NONE, 0);
      add_row(5, OP_WRITE, tx_a, 32'(c3), 4'h1, '0, '0, 1, PIN_NONE, 0);
      add_row(5, OP_WAIT, st_a, '0, '0, 32'h7, 32'h6, 1, PIN_NONE, 0);
      add_row(5, OP_READ, rx_a, '0, '0, '1, 32'(c3), 1, PIN_NONE, 0);
      add_row(5, OP_READ, st_a, '0, '0, 32'h7, 32'h0, 1, PIN_NONE, 0);
      // Region 0 falls through to main RAM once boot is cleared
      add_row(6, OP_WRITE, region_addr(3, 'h0), '0, 4'hF, '0, '0, 1, PIN_BOOT, 0);
      add_row(6, OP_READ, region_addr(3, 'h0), '0, '0, '1, 32'd0, 1, PIN_NONE, 0);
      add_row(6, OP_READ, region_addr(0, 'h20), '0, '0, '1, m1, 1, PIN_NONE, 0);
   endtask

   initial begin
      reset      = 1'b1;
      m_valid    = 1'b0;
      m_addr.raw = '0;
      m_wdata    = '0;
      m_wstrb    = '0;
      cts        = 1'b1;
      rxd        = 1'b1;
      lfsr       = LFSR_SEED;
      n_pass     = 0;
      n_fail     = 0;
      test_fail  = 0;
      timed_out  = 1'b0;
      test_name  = '{"reset state", "boot ram byte merge", "remap while booting",
                     "uart loopback", "flow control", "overrun", "soft reset"};
      build_table();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check(!m_ready && boot_mode && rts && txd && !core_reset,
            "outputs after reset not at their idle values");
      $display("Test 0 %s: %0d errors", test_name[0], test_fail);
      test_fail = 0;
      for (int i = 0; i < rows.size(); i++) begin
         run_row(rows[i]);
         if (timed_out || i == rows.size() - 1 || rows[i+1].test != rows[i].test) begin
            $display("Test %0d %s: %0d errors", rows[i].test, test_name[rows[i].test],
                     test_fail);
            test_fail = 0;
         end
         if (timed_out) begin
            break;
         end
      end
      $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
common/soc_pkg.sv
rtl/bus_interconnect.sv
rtl/soc_ram.sv
rtl/reset_ctrl.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_regs.sv
rtl/soc_system.sv
verif/soc_system_tb.sv
